//--- all.f
+incdir+src
src/cpu_pkg.sv
src/alu.sv
src/register_file.sv
src/data_format_decoder.sv
src/branch_decoder.sv
src/control_unit.sv
src/datapath.sv
src/cpu_core.sv
dv/cpu_core_assert.sv
dv/cpu_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f all.f --top-module cpu_core_tb -o cpu_core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/cpu_core_sim +verilator+error+limit+100 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

//--- dv/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;

    localparam int num_instructions = 2000;
    localparam int reset_cycles     = 8;
    localparam int timeout_cycles   = 2 * num_instructions + reset_cycles + 100;

    logic            clock;
    logic            reset;
    cpu_pkg::word_t  instr_address;
    cpu_pkg::instr_t instruction;
    cpu_pkg::word_t  data_address;
    logic            data_write;
    cpu_pkg::word_t  data_write_data;
    logic            data_read;
    cpu_pkg::word_t  data_read_data;

    cpu_pkg::instr_t program_memory [256];
    cpu_pkg::word_t  data_memory [64];

    // Instruction-level model
    cpu_pkg::word_t  model_registers [32];
    cpu_pkg::word_t  model_memory [64];
    cpu_pkg::word_t  model_pc;
    logic            load_pending;
    int              instr_count = 0;
    int              cycle_count = 0;
    integer          seed = 32'h7edf;

    cpu_core cpu_core_inst (
        .clock           (clock),
        .reset           (reset),
        .instr_address   (instr_address),
        .instruction     (instruction),
        .data_address    (data_address),
        .data_write      (data_write),
        .data_write_data (data_write_data),
        .data_read       (data_read),
        .data_read_data  (data_read_data)
    );

    always #2 clock = ~clock;

    // Combinational fetch from 256 words that wrap
    assign instruction = program_memory[instr_address[9:2]];

    // One-cycle read latency
    always @(posedge clock) begin
        if (data_write) begin
            data_memory[data_address[8:3]] <= data_write_data;
        end
        if (data_read) begin
            data_read_data <= data_memory[data_address[8:3]];
        end
    end

    task automatic stop_run;
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string message);
        $display("%s", message);
        stop_run();
    endtask

    task automatic check_word(input string name, input cpu_pkg::word_t actual,
                              input cpu_pkg::word_t expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_address(input string name, input cpu_pkg::word_t actual,
                                 input cpu_pkg::word_t expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h at instruction %0d",
                     name, actual, expected, instr_count);
            stop_run();
        end
    endtask

    function automatic cpu_pkg::word_t reg_value(input cpu_pkg::reg_index_t index);
        if (index == 5'd31) begin
            return '0;
        end
        return model_registers[index];
    endfunction

    task automatic write_register(input cpu_pkg::reg_index_t index,
                                  input cpu_pkg::word_t value);
        if (index != 5'd31) begin
            model_registers[index] = value;
        end
    endtask

    task automatic fill_data_memory;
        for (int i = 0; i < 64; i++) begin
            data_memory[i]  = cpu_pkg::word_t'(i + 1) * 64'h9e37_79b9_7f4a_7c15;
            model_memory[i] = data_memory[i];
        end
    endtask

    // X26 holds 1 and X27 toggles, so the backward branch at each
    // slot 15 runs its loop at most twice
    task automatic fill_program;
        logic [31:0] value;
        logic [31:0] extra;
        logic [7:0]  pick;
        logic [4:0]  rd;
        logic [4:0]  rn;
        logic [4:0]  rm;
        for (int i = 0; i < 256; i++) begin
            value = $random(seed);
            extra = $random(seed);
            pick  = value[31:24] % 8'd14;
            rd    = value[4:0];
            if (rd == 5'd26 || rd == 5'd27) begin
                rd = 5'd31;
            end
            rn = value[9:5];
            rm = value[14:10];
            if (i == 0) begin
                // Fetched while reset is held, so data_read must stay low there
                program_memory[i] = {11'b11111000010, 9'd0, 2'b00, 5'd31, 5'd31};
            end else if (i == 1) begin
                program_memory[i] = {9'b110100101, 2'b00, 16'd1, 5'd26};
            end else if (i % 16 == 14) begin
                program_memory[i] = {11'b11001011000, 5'd27, 6'b0, 5'd26, 5'd27};
            end else if (i % 16 == 15) begin
                program_memory[i] = {7'b1011010, extra[3], 19'h7fffe, 5'd27};
            end else begin
                case (pick)
                    8'd0: program_memory[i] = {11'b10001011000, rm, 6'b0, rn, rd};
                    8'd1: program_memory[i] = {11'b11001011000, rm, 6'b0, rn, rd};
                    8'd2: program_memory[i] = {11'b10001010000, rm, 6'b0, rn, rd};
                    8'd3: program_memory[i] = {11'b10101010000, rm, 6'b0, rn, rd};
                    8'd4: program_memory[i] = {10'b1001000100, extra[11:0], rn, rd};
                    8'd5: program_memory[i] = {10'b1101000100, extra[11:0], rn, rd};
                    8'd6: program_memory[i] = {9'b110100101, extra[17:16], extra[15:0], rd};
                    // Base X31 with offsets of -32 to 31 words
                    8'd7, 8'd8: begin
                        program_memory[i] = {11'b11111000010, extra[5:0], 3'b000, 2'b00,
                                             5'd31, rd};
                    end
                    8'd9, 8'd10: begin
                        program_memory[i] = {11'b11111000000, extra[5:0], 3'b000, 2'b00,
                                             5'd31, value[4:0]};
                    end
                    8'd11: program_memory[i] = {6'b000101, 26'(extra[2:0]) + 26'd1};
                    8'd12: begin
                        program_memory[i] = {7'b1011010, extra[3], 19'(extra[2:0]) + 19'd1,
                                             value[4:0]};
                    end
                    default: program_memory[i] = {11'b0, extra[20:0]};
                endcase
            end
        end
    endtask

    task automatic execute_model(input cpu_pkg::instr_t instr);
        cpu_pkg::word_t      op_a;
        cpu_pkg::word_t      op_b;
        cpu_pkg::word_t      address;
        cpu_pkg::word_t      next_pc;
        logic signed [63:0]  offset;
        cpu_pkg::reg_index_t rd;
        logic                store_expected;
        logic                load_expected;
        rd             = instr[4:0];
        op_a           = reg_value(instr[9:5]);
        op_b           = reg_value(instr[20:16]);
        offset         = 64'($signed(instr[20:12]));
        address        = op_a + cpu_pkg::word_t'(offset);
        next_pc        = model_pc + 64'd4;
        store_expected = 1'b0;
        load_expected  = 1'b0;
        casez (instr[31:21])
            11'b10001011000: write_register(rd, op_a + op_b);
            11'b11001011000: write_register(rd, op_a - op_b);
            11'b10001010000: write_register(rd, op_a & op_b);
            11'b10101010000: write_register(rd, op_a | op_b);
            11'b1001000100?: write_register(rd, op_a + {52'b0, instr[21:10]});
            11'b1101000100?: write_register(rd, op_a - {52'b0, instr[21:10]});
            11'b110100101??: begin
                write_register(rd, {48'b0, instr[20:5]} << (16 * instr[22:21]));
            end
            11'b11111000010: load_expected = 1'b1;
            11'b11111000000: store_expected = 1'b1;
            11'b000101?????: begin
                offset  = 64'($signed(instr[25:0]));
                next_pc = model_pc + cpu_pkg::word_t'(offset <<< 2);
            end
            // Bit 24 selects CBNZ
            11'b1011010????: begin
                offset = 64'($signed(instr[23:5]));
                if ((reg_value(rd) == '0) != instr[24]) begin
                    next_pc = model_pc + cpu_pkg::word_t'(offset <<< 2);
                end
            end
            default: begin
            end
        endcase
        if (data_write && !store_expected) begin
            report_failure("Unexpected store on data_write at a non-STUR instruction");
        end
        if (!data_write && store_expected) begin
            report_failure("STUR did not assert data_write");
        end
        if (data_read != load_expected) begin
            report_failure("data_read does not match the first cycle of an LDUR");
        end
        if (store_expected) begin
            check_address("data_address", data_address, address);
            check_word("data_write_data", data_write_data, reg_value(rd));
            model_memory[address[8:3]] = reg_value(rd);
        end
        if (load_expected) begin
            check_address("data_address", data_address, address);
            write_register(rd, model_memory[address[8:3]]);
            load_pending = 1'b1;
        end else begin
            model_pc    = next_pc;
            instr_count = instr_count + 1;
        end
    endtask

    // Outputs are sampled mid-cycle away from the driving edge
    always @(negedge clock) begin
        if (cpu_core_inst.cpu_core_assert_inst.assertion_failed) begin
            report_failure("A bound assertion on cpu_core failed");
        end
        if (reset) begin
            check_address("instr_address", instr_address, '0);
            if (data_write || data_read) begin
                report_failure("Memory strobe active while reset is held");
            end
        end else if (instr_count < num_instructions) begin
            check_address("instr_address", instr_address, model_pc);
            if (load_pending) begin
                if (data_write || data_read) begin
                    report_failure("Memory strobe active in the second cycle of an LDUR");
                end
                load_pending = 1'b0;
                model_pc     = model_pc + 64'd4;
                instr_count  = instr_count + 1;
            end else begin
                execute_model(program_memory[model_pc[9:2]]);
            end
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            report_failure("Timeout, the program did not retire all instructions in time");
        end
    end

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        data_read_data = '0;
        model_pc       = '0;
        load_pending   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_registers[i] = '0;
        end
        fill_data_memory();
        fill_program();
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        wait (instr_count >= num_instructions);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- dv/cpu_core_assert.sv
`timescale 1ns/1ps

module cpu_core_assert (
    input logic           clock,
    input logic           reset,
    input cpu_pkg::word_t instr_address,
    input logic           data_write,
    input logic           data_read
);

    // Set by any failing property, read by the testbench
    logic assertion_failed = 1'b0;

    strobes_exclusive: assert property (@(posedge clock) !(data_write && data_read))
        else begin
            assertion_failed = 1'b1;
            $error("data_write and data_read high in the same cycle");
        end

    // Load wait cycle keeps the fetch address
    read_holds_pc: assert property (@(posedge clock) disable iff (reset)
        data_read |=> $stable(instr_address))
        else begin
            assertion_failed = 1'b1;
            $error("instr_address changed in the cycle after data_read");
        end

    pc_aligned: assert property (@(posedge clock) instr_address[1:0] == 2'b00)
        else begin
            assertion_failed = 1'b1;
            $error("instr_address is not word aligned");
        end

endmodule

bind cpu_core cpu_core_assert cpu_core_assert_inst (
    .clock         (clock),
    .reset         (reset),
    .instr_address (instr_address),
    .data_write    (data_write),
    .data_read     (data_read)
);

//--- src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
    input  logic            clock,
    input  logic            reset,
    output cpu_pkg::word_t  instr_address,
    input  cpu_pkg::instr_t instruction,
    output cpu_pkg::word_t  data_address,
    output logic            data_write,
    output cpu_pkg::word_t  data_write_data,
    output logic            data_read,
    input  cpu_pkg::word_t  data_read_data
);

    cpu_pkg::control_word_t control_word;
    cpu_pkg::word_t         constant;
    logic                   advance;
    logic                   zero;

    control_unit control_unit_inst (
        .clock        (clock),
        .reset        (reset),
        .instruction  (instruction),
        .zero         (zero),
        .control_word (control_word),
        .constant     (constant),
        .advance      (advance)
    );

    datapath datapath_inst (
        .clock           (clock),
        .reset           (reset),
        .control_word    (control_word),
        .constant        (constant),
        .advance         (advance),
        .zero            (zero),
        .instr_address   (instr_address),
        .data_address    (data_address),
        .data_write      (data_write),
        .data_write_data (data_write_data),
        .data_read       (data_read),
        .data_read_data  (data_read_data)
    );

endmodule

//--- src/datapath.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module datapath (
    input  logic                   clock,
    input  logic                   reset,
    input  cpu_pkg::control_word_t control_word,
    input  cpu_pkg::word_t         constant,
    input  logic                   advance,
    output logic                   zero,
    output cpu_pkg::word_t         instr_address,
    output cpu_pkg::word_t         data_address,
    output logic                   data_write,
    output cpu_pkg::word_t         data_write_data,
    output logic                   data_read,
    input  cpu_pkg::word_t         data_read_data
);

    cpu_pkg::word_t     pc;
    cpu_pkg::word_t     data_a;
    cpu_pkg::word_t     data_b;
    cpu_pkg::word_t     alu_b;
    cpu_pkg::word_t     alu_result;
    cpu_pkg::word_t     write_back;
    cpu_pkg::alu_op_t   alu_operation;
    cpu_pkg::pc_select_t pc_select;

    assign alu_operation = cpu_pkg::alu_op_t'(control_word[`CPU_CW_ALU_OP]);
    assign pc_select     = cpu_pkg::pc_select_t'(control_word[`CPU_CW_PC_SELECT]);

    register_file register_file_inst (
        .clock        (clock),
        .reset        (reset),
        .read_a       (control_word[`CPU_CW_READ_A]),
        .read_b       (control_word[`CPU_CW_READ_B]),
        .write_index  (control_word[`CPU_CW_WRITE_REG]),
        .write_enable (control_word[`CPU_CW_REG_WRITE] && advance),
        .write_data   (write_back),
        .data_a       (data_a),
        .data_b       (data_b)
    );

    assign alu_b = control_word[`CPU_CW_ALU_SRC_CONSTANT] ? constant : data_b;

    alu alu_inst (
        .operation (alu_operation),
        .a         (data_a),
        .b         (alu_b),
        .result    (alu_result),
        .zero      (zero)
    );

    assign write_back = control_word[`CPU_CW_MEM_TO_REG] ? data_read_data : alu_result;

    // Conditional branches arrive already resolved to pc_offset or pc_next
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (advance) begin
            if (pc_select == cpu_pkg::pc_offset) begin
                pc <= pc + constant;
            end else begin
                pc <= pc + 64'd4;
            end
        end
    end

    assign instr_address   = pc;
    assign data_address    = alu_result;
    assign data_write_data = data_b;

    // Strobes stay quiet while reset is held
    assign data_read  = control_word[`CPU_CW_MEM_READ] && !reset;
    assign data_write = control_word[`CPU_CW_MEM_WRITE] && advance && !reset;

endmodule

//--- src/control_unit.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module control_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  cpu_pkg::instr_t       instruction,
    input  logic                  zero,
    output cpu_pkg::control_word_t control_word,
    output cpu_pkg::word_t        constant,
    output logic                  advance
);

    cpu_pkg::step_t         step;
    cpu_pkg::step_t         next_step;
    cpu_pkg::step_t         data_next_step;
    cpu_pkg::step_t         branch_next_step;
    cpu_pkg::control_word_t data_control_word;
    cpu_pkg::control_word_t branch_control_word;
    cpu_pkg::control_word_t selected_word;
    cpu_pkg::word_t         data_constant;
    cpu_pkg::word_t         branch_constant;
    logic                   branch_group;
    logic                   take_branch;

    data_format_decoder data_format_decoder_inst (
        .instruction  (instruction),
        .step         (step),
        .control_word (data_control_word),
        .constant     (data_constant),
        .next_step    (data_next_step)
    );

    branch_decoder branch_decoder_inst (
        .instruction  (instruction),
        .step         (step),
        .control_word (branch_control_word),
        .constant     (branch_constant),
        .next_step    (branch_next_step)
    );

    // B, CBZ and CBNZ all carry 101 in bits 28 to 26
    assign branch_group = (instruction[28:26] == 3'b101);

    always_comb begin
        if (branch_group) begin
            selected_word = branch_control_word;
            constant      = branch_constant;
            next_step     = branch_next_step;
        end else begin
            selected_word = data_control_word;
            constant      = data_constant;
            next_step     = data_next_step;
        end
    end

    // Bit 24 set means CBNZ, so the zero test flips
    assign take_branch = zero ^ instruction[24];

    always_comb begin
        control_word = selected_word;
        if (cpu_pkg::pc_select_t'(selected_word[`CPU_CW_PC_SELECT]) ==
                cpu_pkg::pc_offset_if_zero) begin
            control_word[`CPU_CW_PC_SELECT] = take_branch ? cpu_pkg::pc_offset
                                                          : cpu_pkg::pc_next;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            step <= cpu_pkg::step_first;
        end else begin
            step <= next_step;
        end
    end

    assign advance = (next_step == cpu_pkg::step_first);

endmodule

//--- src/branch_decoder.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module branch_decoder (
    input  cpu_pkg::instr_t        instruction,
    input  cpu_pkg::step_t         step,
    output cpu_pkg::control_word_t control_word,
    output cpu_pkg::word_t         constant,
    output cpu_pkg::step_t         next_step
);

    logic is_b;
    logic is_cb;

    assign is_b  = (instruction[31:26] == 6'b000101);
    // CBZ and CBNZ differ only in bit 24
    assign is_cb = (instruction[31:25] == 7'b1011010);

    always_comb begin
        control_word = '0;
        constant     = '0;
        next_step    = cpu_pkg::step_first;
        if (step == cpu_pkg::step_first) begin
            if (is_b) begin
                control_word[`CPU_CW_PC_SELECT] = cpu_pkg::pc_offset;
                constant = {{(`CPU_WORD_WIDTH-28){instruction[25]}}, instruction[25:0], 2'b00};
            end else if (is_cb) begin
                // Rt through the ALU gives the zero flag
                control_word[`CPU_CW_READ_B]    = instruction[4:0];
                control_word[`CPU_CW_ALU_OP]    = cpu_pkg::alu_pass_b;
                control_word[`CPU_CW_PC_SELECT] = cpu_pkg::pc_offset_if_zero;
                constant = {{(`CPU_WORD_WIDTH-21){instruction[23]}}, instruction[23:5], 2'b00};
            end
        end
    end

endmodule

//--- src/data_format_decoder.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module data_format_decoder (
    input  cpu_pkg::instr_t        instruction,
    input  cpu_pkg::step_t         step,
    output cpu_pkg::control_word_t control_word,
    output cpu_pkg::word_t         constant,
    output cpu_pkg::step_t         next_step
);

    // Matched against bits 31 to 21
    localparam logic [10:0] opcode_add  = 11'b10001011000;
    localparam logic [10:0] opcode_sub  = 11'b11001011000;
    localparam logic [10:0] opcode_and  = 11'b10001010000;
    localparam logic [10:0] opcode_orr  = 11'b10101010000;
    localparam logic [10:0] opcode_addi = 11'b1001000100?;
    localparam logic [10:0] opcode_subi = 11'b1101000100?;
    localparam logic [10:0] opcode_movz = 11'b110100101??;
    localparam logic [10:0] opcode_ldur = 11'b11111000010;
    localparam logic [10:0] opcode_stur = 11'b11111000000;

    logic [10:0] opcode;

    assign opcode = instruction[31:21];

    always_comb begin
        control_word = '0;
        constant     = '0;
        next_step    = cpu_pkg::step_first;
        casez (opcode)
            opcode_add, opcode_sub, opcode_and, opcode_orr: begin
                control_word[`CPU_CW_READ_A]    = instruction[9:5];
                control_word[`CPU_CW_READ_B]    = instruction[20:16];
                control_word[`CPU_CW_WRITE_REG] = instruction[4:0];
                control_word[`CPU_CW_REG_WRITE] = 1'b1;
                case (opcode)
                    opcode_sub: control_word[`CPU_CW_ALU_OP] = cpu_pkg::alu_sub;
                    opcode_and: control_word[`CPU_CW_ALU_OP] = cpu_pkg::alu_and;
                    opcode_orr: control_word[`CPU_CW_ALU_OP] = cpu_pkg::alu_orr;
                    default:    control_word[`CPU_CW_ALU_OP] = cpu_pkg::alu_add;
                endcase
            end
            opcode_addi, opcode_subi: begin
                control_word[`CPU_CW_READ_A]           = instruction[9:5];
                control_word[`CPU_CW_WRITE_REG]        = instruction[4:0];
                control_word[`CPU_CW_REG_WRITE]        = 1'b1;
                control_word[`CPU_CW_ALU_SRC_CONSTANT] = 1'b1;
                // SUBI differs from ADDI only in bit 30
                control_word[`CPU_CW_ALU_OP] = instruction[30] ? cpu_pkg::alu_sub
                                                               : cpu_pkg::alu_add;
                constant = cpu_pkg::word_t'(instruction[21:10]);
            end
            opcode_movz: begin
                control_word[`CPU_CW_WRITE_REG]        = instruction[4:0];
                control_word[`CPU_CW_REG_WRITE]        = 1'b1;
                control_word[`CPU_CW_ALU_SRC_CONSTANT] = 1'b1;
                control_word[`CPU_CW_ALU_OP]           = cpu_pkg::alu_pass_b;
                // hw picks one of four 16-bit lanes
                constant = cpu_pkg::word_t'(instruction[20:5]) << {instruction[22:21], 4'b0000};
            end
            opcode_ldur: begin
                if (step == cpu_pkg::step_first) begin
                    control_word[`CPU_CW_READ_A]           = instruction[9:5];
                    control_word[`CPU_CW_ALU_SRC_CONSTANT] = 1'b1;
                    control_word[`CPU_CW_ALU_OP]           = cpu_pkg::alu_add;
                    control_word[`CPU_CW_MEM_READ]         = 1'b1;
                    next_step = cpu_pkg::step_load_wait;
                end else begin
                    // Memory word arrives this cycle
                    control_word[`CPU_CW_WRITE_REG]  = instruction[4:0];
                    control_word[`CPU_CW_REG_WRITE]  = 1'b1;
                    control_word[`CPU_CW_MEM_TO_REG] = 1'b1;
                end
                constant = {{(`CPU_WORD_WIDTH-9){instruction[20]}}, instruction[20:12]};
            end
            opcode_stur: begin
                control_word[`CPU_CW_READ_A]           = instruction[9:5];
                control_word[`CPU_CW_READ_B]           = instruction[4:0];
                control_word[`CPU_CW_ALU_SRC_CONSTANT] = 1'b1;
                control_word[`CPU_CW_ALU_OP]           = cpu_pkg::alu_add;
                control_word[`CPU_CW_MEM_WRITE]        = 1'b1;
                constant = {{(`CPU_WORD_WIDTH-9){instruction[20]}}, instruction[20:12]};
            end
            default: begin
            end
        endcase
    end

endmodule

//--- src/register_file.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module register_file (
    input  logic                clock,
    input  logic                reset,
    input  cpu_pkg::reg_index_t read_a,
    input  cpu_pkg::reg_index_t read_b,
    input  cpu_pkg::reg_index_t write_index,
    input  logic                write_enable,
    input  cpu_pkg::word_t      write_data,
    output cpu_pkg::word_t      data_a,
    output cpu_pkg::word_t      data_b
);

    localparam cpu_pkg::reg_index_t zero_register = cpu_pkg::reg_index_t'(`CPU_REG_COUNT - 1);

    cpu_pkg::word_t registers [`CPU_REG_COUNT];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable && (write_index != zero_register)) begin
            registers[write_index] <= write_data;
        end
    end

    // X31 always reads as zero
    assign data_a = (read_a == zero_register) ? '0 : registers[read_a];
    assign data_b = (read_b == zero_register) ? '0 : registers[read_b];

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t operation,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   result,
    output logic             zero
);

    always_comb begin
        case (operation)
            cpu_pkg::alu_add: begin
                result = a + b;
            end
            cpu_pkg::alu_sub: begin
                result = a - b;
            end
            cpu_pkg::alu_and: begin
                result = a & b;
            end
            cpu_pkg::alu_orr: begin
                result = a | b;
            end
            cpu_pkg::alu_pass_b: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- src/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    // Data value or byte address
    typedef logic [`CPU_WORD_WIDTH-1:0] word_t;

    typedef logic [`CPU_INSTR_WIDTH-1:0] instr_t;

    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_index_t;

    // Fields placed by the CPU_CW_* macros
    typedef logic [`CPU_CONTROL_WIDTH-1:0] control_word_t;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_orr    = 3'd3,
        alu_pass_b = 3'd4
    } alu_op_t;

    // Only LDUR ever leaves step_first
    typedef enum logic [1:0] {
        step_first     = 2'd0,
        step_load_wait = 2'd1
    } step_t;

    typedef enum logic [1:0] {
        pc_next           = 2'd0,
        pc_offset         = 2'd1,
        pc_offset_if_zero = 2'd2
    } pc_select_t;

endpackage

//--- src/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_WORD_WIDTH 64
`define CPU_INSTR_WIDTH 32
`define CPU_REG_COUNT 32
`define CPU_CONTROL_WIDTH 25

// Control word fields, from the top bit down
`define CPU_CW_READ_A 24:20
`define CPU_CW_READ_B 19:15
`define CPU_CW_WRITE_REG 14:10
`define CPU_CW_REG_WRITE 9
`define CPU_CW_ALU_SRC_CONSTANT 8
`define CPU_CW_ALU_OP 7:5
`define CPU_CW_MEM_WRITE 4
`define CPU_CW_MEM_READ 3
`define CPU_CW_MEM_TO_REG 2
`define CPU_CW_PC_SELECT 1:0

`endif
